// File: include/csi2_ecc_masks.svh
// CSI-2 packet header Hamming parity masks.
// Bit b of mask k set means header data bit b feeds parity bit k.
// The six masks are packed so that ECC_MASKS[k] selects mask k.

localparam logic [5 : 0][23 : 0] ECC_MASKS = {
  24'hEFFC00, // P5.
  24'hDF03F0, // P4.
  24'hB8E38E, // P3.
  24'h749A6D, // P2.
  24'hF2555B, // P1.
  24'hF12CB7  // P0.
};

// File: source/csi2_pkg.sv
package csi2_pkg;

`include "csi2_ecc_masks.svh"

// ==========================================================================
// Widths and codes
// ==========================================================================

localparam int WORD_W    = 32;
localparam int DATA_BITS = 24;           // Header bits under ECC.
localparam int SYND_W    = 6;
localparam int POS_W     = 5;
localparam int CNT_W     = 16;
localparam int DI_W      = 8;
localparam int WC_W      = 16;
localparam int DT_W      = 6;            // Data type field of DI.
localparam int PAY_CNT_W = WC_W - 1;     // Holds ceil(wc/4).

localparam logic [POS_W - 1 : 0] POS_NONE        = 5'd31;
localparam logic [POS_W - 1 : 0] POS_PARITY_BASE = 5'd24;
localparam logic [DT_W - 1 : 0]  LONG_DI_MIN     = 6'd16;

// ==========================================================================
// Header word, raw and field views
// ==========================================================================

typedef struct packed {
  logic [1 : 0]          pad;
  logic [SYND_W - 1 : 0] ecc;
  logic [WC_W - 1 : 0]   wc;
  logic [DI_W - 1 : 0]   di;
} hdr_fields_t;

typedef union packed {
  logic [WORD_W - 1 : 0] raw;
  hdr_fields_t           f;
} hdr_word_t;

function automatic logic [SYND_W - 1 : 0] calc_ecc( input logic [DATA_BITS - 1 : 0] data );
  logic [SYND_W - 1 : 0] ecc;
  for( int k = 0; k < SYND_W; k++ )
    ecc[k] = ^( data & ECC_MASKS[k] );
  return ecc;
endfunction

endpackage

// File: source/csi2_hdr_if.sv
`timescale 1ns/1ps

interface csi2_hdr_if;

csi2_pkg::hdr_word_t                hdr;          // Corrected header.
logic                               hdr_valid;
logic                               err;
logic                               corr;
logic                               word_valid;
logic [csi2_pkg::WORD_W - 1 : 0]    word;
logic                               pkt_done;

modport dec (
  output hdr_valid, hdr, err, corr, word_valid, word,
  input  pkt_done
);

modport trk (
  input  hdr_valid, hdr, err, corr, word_valid, word,
  output pkt_done
);

endinterface

// File: source/csi2_syndrome_lut.sv
`timescale 1ns/1ps

module csi2_syndrome_lut
(
  input  logic                               clk_i,
  input  logic                               srst_i,
  input  logic [csi2_pkg::SYND_W - 1 : 0]    synd_i,
  output logic [csi2_pkg::POS_W - 1 : 0]     pos_o
);

typedef logic [( 1 << csi2_pkg::SYND_W ) - 1 : 0][csi2_pkg::POS_W - 1 : 0] pos_tbl_t;

// Syndrome to bit position, derived from the parity masks.
function automatic pos_tbl_t build_pos_tbl();
  pos_tbl_t                    tbl;
  logic [csi2_pkg::SYND_W - 1 : 0] col;
  for( int s = 0; s < ( 1 << csi2_pkg::SYND_W ); s++ )
    tbl[s] = csi2_pkg::POS_NONE;
  tbl[0] = '0;
  for( int p = 0; p < csi2_pkg::SYND_W; p++ )
    tbl[1 << p] = csi2_pkg::POS_PARITY_BASE + csi2_pkg::POS_W'( p ); // Parity bit hit.
  for( int b = 0; b < csi2_pkg::DATA_BITS; b++ )
    begin
      for( int k = 0; k < csi2_pkg::SYND_W; k++ )
        col[k] = csi2_pkg::ECC_MASKS[k][b];
      tbl[col] = csi2_pkg::POS_W'( b );
    end
  return tbl;
endfunction

localparam pos_tbl_t POS_TBL = build_pos_tbl();

always_ff @( posedge clk_i, posedge srst_i )
  if( srst_i )
    pos_o <= '0;
  else
    pos_o <= POS_TBL[synd_i];            // One read per clock.

endmodule

// File: source/csi2_hamming_dec.sv
`timescale 1ns/1ps

module csi2_hamming_dec
(
  input  logic                               clk_i,
  input  logic                               srst_i,
  input  logic                               valid_i,
  input  logic [csi2_pkg::WORD_W - 1 : 0]    data_i,
  csi2_hdr_if.dec                            hdr,
  output logic [csi2_pkg::CNT_W - 1 : 0]     err_cnt_o,
  output logic [csi2_pkg::CNT_W - 1 : 0]     corr_cnt_o
);

csi2_pkg::hdr_word_t                  data_in;
logic [csi2_pkg::SYND_W - 1 : 0]      syndrome;
logic [csi2_pkg::POS_W - 1 : 0]       err_pos;
logic [csi2_pkg::WORD_W - 1 : 0]      data_d;
logic                                 valid_d;
logic                                 header_passed;
logic                                 header_valid;
logic                                 error_detected;
logic                                 correctable;
logic [csi2_pkg::WORD_W - 1 : 0]      corrected;
csi2_pkg::hdr_word_t                  data_q;
logic                                 valid_q;
logic                                 hdr_valid_q;
logic                                 err_q;
logic                                 corr_q;

// ==========================================================================
// Syndrome, stage 1
// ==========================================================================

assign data_in  = data_i;
assign syndrome = csi2_pkg::calc_ecc( data_in.raw[csi2_pkg::DATA_BITS - 1 : 0] ) ^ data_in.f.ecc;

csi2_syndrome_lut synd_lut (
  .clk_i      ( clk_i    ),
  .srst_i     ( srst_i   ),
  .synd_i     ( syndrome ),
  .pos_o      ( err_pos  )
);

always_ff @( posedge clk_i )
  data_d <= data_i;

always_ff @( posedge clk_i, posedge srst_i )
  if( srst_i )
    begin
      valid_d        <= 1'b0;
      error_detected <= 1'b0;
    end
  else
    if( hdr.pkt_done )
      begin
        valid_d        <= 1'b0;
        error_detected <= 1'b0;
      end
    else
      begin
        valid_d        <= valid_i;
        error_detected <= ( syndrome != '0 );
      end

// Only the first word after pkt_done is a header.
assign header_valid = valid_d && !header_passed && !hdr.pkt_done;
assign correctable  = error_detected && ( err_pos != csi2_pkg::POS_NONE );

always_ff @( posedge clk_i, posedge srst_i )
  if( srst_i )
    header_passed <= 1'b0;
  else
    if( hdr.pkt_done )
      header_passed <= 1'b0;
    else
      if( header_valid )
        header_passed <= 1'b1;

// ==========================================================================
// Correction and flags, stage 2
// ==========================================================================

always_comb
  begin
    corrected = data_d;
    if( header_valid && correctable && ( err_pos < csi2_pkg::POS_PARITY_BASE ) )
      corrected[err_pos] = ~data_d[err_pos];   // Parity hits leave data alone.
  end

always_ff @( posedge clk_i )
  data_q.raw <= corrected;

always_ff @( posedge clk_i, posedge srst_i )
  if( srst_i )
    begin
      valid_q     <= 1'b0;
      hdr_valid_q <= 1'b0;
      err_q       <= 1'b0;
      corr_q      <= 1'b0;
    end
  else
    if( hdr.pkt_done )
      begin
        valid_q     <= 1'b0;
        hdr_valid_q <= 1'b0;
        err_q       <= 1'b0;
        corr_q      <= 1'b0;
      end
    else
      begin
        valid_q     <= valid_d;
        hdr_valid_q <= header_valid;
        if( header_valid )
          begin
            err_q  <= error_detected;
            corr_q <= correctable;
          end
      end

// Running totals, saturating.
always_ff @( posedge clk_i, posedge srst_i )
  if( srst_i )
    begin
      err_cnt_o  <= '0;
      corr_cnt_o <= '0;
    end
  else
    if( header_valid && error_detected )
      begin
        if( err_cnt_o != '1 )
          err_cnt_o <= err_cnt_o + 1'b1;
        if( correctable && ( corr_cnt_o != '1 ) )
          corr_cnt_o <= corr_cnt_o + 1'b1;
      end

assign hdr.hdr_valid  = hdr_valid_q;
assign hdr.hdr        = data_q;
assign hdr.err        = err_q;
assign hdr.corr       = corr_q;
assign hdr.word_valid = valid_q;
assign hdr.word       = data_q.raw;

endmodule

// File: source/csi2_pkt_tracker.sv
`timescale 1ns/1ps

module csi2_pkt_tracker
(
  input  logic                               clk_i,
  input  logic                               srst_i,
  csi2_hdr_if.trk                            hdr,
  output logic                               hdr_valid_o,
  output logic [csi2_pkg::DI_W - 1 : 0]      hdr_di_o,
  output logic [csi2_pkg::WC_W - 1 : 0]      hdr_wc_o,
  output logic                               hdr_err_o,
  output logic                               hdr_corr_o,
  output logic                               payload_valid_o,
  output logic [csi2_pkg::WORD_W - 1 : 0]    payload_o,
  output logic                               pkt_done_o
);

logic [csi2_pkg::WC_W : 0]            wc_sum;
logic [csi2_pkg::PAY_CNT_W - 1 : 0]   wc_words;
logic [csi2_pkg::PAY_CNT_W - 1 : 0]   pay_cnt;
logic                                 is_long;
logic                                 uncorrectable;
logic                                 take_payload;

// Payload length in words is ceil(wc/4).
assign wc_sum        = { 1'b0, hdr.hdr.f.wc } + ( csi2_pkg::WC_W + 1 )'( 3 );
assign wc_words      = wc_sum[csi2_pkg::WC_W : 2];
assign is_long       = hdr.hdr.f.di[csi2_pkg::DT_W - 1 : 0] >= csi2_pkg::LONG_DI_MIN;
assign uncorrectable = hdr.err && !hdr.corr;
assign take_payload  = hdr.word_valid && !hdr.hdr_valid && ( pay_cnt != '0 );

assign hdr.pkt_done  = pkt_done_o;

always_ff @( posedge clk_i, posedge srst_i )
  if( srst_i )
    pay_cnt <= '0;
  else
    if( hdr.hdr_valid )
      pay_cnt <= ( is_long && !uncorrectable ) ? wc_words : '0;
    else
      if( take_payload )
        pay_cnt <= pay_cnt - 1'b1;

always_ff @( posedge clk_i, posedge srst_i )
  if( srst_i )
    pkt_done_o <= 1'b0;
  else
    if( hdr.hdr_valid )
      pkt_done_o <= !is_long || uncorrectable || ( wc_words == '0 );
    else
      pkt_done_o <= take_payload && ( pay_cnt == csi2_pkg::PAY_CNT_W'( 1 ) ); // Last word.

always_ff @( posedge clk_i, posedge srst_i )
  if( srst_i )
    begin
      hdr_valid_o     <= 1'b0;
      payload_valid_o <= 1'b0;
      hdr_err_o       <= 1'b0;
      hdr_corr_o      <= 1'b0;
    end
  else
    begin
      hdr_valid_o     <= hdr.hdr_valid;
      payload_valid_o <= take_payload;
      hdr_err_o       <= hdr.err;           // Levels for the whole packet.
      hdr_corr_o      <= hdr.corr;
    end

always_ff @( posedge clk_i )
  begin
    if( hdr.hdr_valid )
      begin
        hdr_di_o <= hdr.hdr.f.di;
        hdr_wc_o <= hdr.hdr.f.wc;
      end
    if( take_payload )
      payload_o <= hdr.word;
  end

endmodule

// File: source/csi2_rx_top.sv
`timescale 1ns/1ps

module csi2_rx_top
(
  input  logic                               clk_i,
  input  logic                               srst_i,
  input  logic                               valid_i,
  input  logic [csi2_pkg::WORD_W - 1 : 0]    data_i,
  output logic                               hdr_valid_o,
  output logic [csi2_pkg::DI_W - 1 : 0]      hdr_di_o,
  output logic [csi2_pkg::WC_W - 1 : 0]      hdr_wc_o,
  output logic                               hdr_err_o,
  output logic                               hdr_corr_o,
  output logic                               payload_valid_o,
  output logic [csi2_pkg::WORD_W - 1 : 0]    payload_o,
  output logic                               pkt_done_o,
  output logic [csi2_pkg::CNT_W - 1 : 0]     err_cnt_o,
  output logic [csi2_pkg::CNT_W - 1 : 0]     corr_cnt_o
);

csi2_hdr_if hdr_bus ();

csi2_hamming_dec hamming_dec (
  .clk_i           ( clk_i           ),
  .srst_i          ( srst_i          ),
  .valid_i         ( valid_i         ),
  .data_i          ( data_i          ),
  .hdr             ( hdr_bus.dec     ),
  .err_cnt_o       ( err_cnt_o       ),
  .corr_cnt_o      ( corr_cnt_o      )
);

csi2_pkt_tracker pkt_tracker (
  .clk_i           ( clk_i           ),
  .srst_i          ( srst_i          ),
  .hdr             ( hdr_bus.trk     ),
  .hdr_valid_o     ( hdr_valid_o     ),
  .hdr_di_o        ( hdr_di_o        ),
  .hdr_wc_o        ( hdr_wc_o        ),
  .hdr_err_o       ( hdr_err_o       ),
  .hdr_corr_o      ( hdr_corr_o      ),
  .payload_valid_o ( payload_valid_o ),
  .payload_o       ( payload_o       ),
  .pkt_done_o      ( pkt_done_o      )
);

endmodule

// File: verification/tb_clk_gen.sv
`timescale 1ns/1ps

module tb_clk_gen #(
  parameter int PERIOD_NS = 8
)
(
  output logic clk_o
);

initial
  clk_o = 1'b0;

always
  #( PERIOD_NS / 2 ) clk_o = ~clk_o;

endmodule

// File: verification/csi2_rx_tb.sv
`timescale 1ns/1ps

module csi2_rx_tb;

`include "csi2_ecc_masks.svh"

localparam int CLK_PERIOD = 8;
localparam int CLS_NONE   = 0;
localparam int CLS_CORR   = 1;
localparam int CLS_UNCORR = 2;

// Flags travel in the pad bits of the header word as {err, corr}.
typedef struct packed {
  logic                            is_hdr;
  logic                            done;
  logic [15 : 0]                   test;
  csi2_pkg::hdr_word_t             hdr;
  logic [csi2_pkg::WORD_W - 1 : 0] word;
} exp_item_t;

logic                               clk_i;
logic                               srst_i;
logic                               valid_i;
logic [csi2_pkg::WORD_W - 1 : 0]    data_i;
logic                               hdr_valid_o;
logic [csi2_pkg::DI_W - 1 : 0]      hdr_di_o;
logic [csi2_pkg::WC_W - 1 : 0]      hdr_wc_o;
logic                               hdr_err_o;
logic                               hdr_corr_o;
logic                               payload_valid_o;
logic [csi2_pkg::WORD_W - 1 : 0]    payload_o;
logic                               pkt_done_o;
logic [csi2_pkg::CNT_W - 1 : 0]     err_cnt_o;
logic [csi2_pkg::CNT_W - 1 : 0]     corr_cnt_o;

string                              names[$];
logic [7 : 0]                       di_q[$];
logic [15 : 0]                      wc_q[$];
logic [31 : 0]                      mask_q[$];
int                                 cls_q[$];
exp_item_t                          exp_q[$];    // Scoreboard.
logic [csi2_pkg::CNT_W - 1 : 0]     exp_err  = '0;
logic [csi2_pkg::CNT_W - 1 : 0]     exp_corr = '0;
int                                 total_words = 0;
bit                                 loaded = 1'b0;

tb_clk_gen #( .PERIOD_NS( CLK_PERIOD ) ) clk_gen ( .clk_o( clk_i ) );

csi2_rx_top UUT (
  .clk_i           ( clk_i           ),
  .srst_i          ( srst_i          ),
  .valid_i         ( valid_i         ),
  .data_i          ( data_i          ),
  .hdr_valid_o     ( hdr_valid_o     ),
  .hdr_di_o        ( hdr_di_o        ),
  .hdr_wc_o        ( hdr_wc_o        ),
  .hdr_err_o       ( hdr_err_o       ),
  .hdr_corr_o      ( hdr_corr_o      ),
  .payload_valid_o ( payload_valid_o ),
  .payload_o       ( payload_o       ),
  .pkt_done_o      ( pkt_done_o      ),
  .err_cnt_o       ( err_cnt_o       ),
  .corr_cnt_o      ( corr_cnt_o      )
);

// ==========================================================================
// Reference model helpers
// ==========================================================================

function automatic logic [5 : 0] ecc_of( input logic [23 : 0] data );
  logic [5 : 0] p;
  for( int k = 0; k < 6; k++ )
    p[k] = ^( data & ECC_MASKS[k] );
  return p;
endfunction

function automatic int len_words( input logic [7 : 0] di, input logic [15 : 0] wc );
  if( di[5 : 0] < csi2_pkg::LONG_DI_MIN )
    return 0;                                // Short packet.
  return ( int'( wc ) + 3 ) / 4;
endfunction

function automatic int pay_words( input logic [7 : 0] di, input logic [15 : 0] wc, input int cls );
  if( cls == CLS_UNCORR )
    return 0;                                // Dropped.
  return len_words( di, wc );
endfunction

// Behind a bad header only the words still in flight are driven.
function automatic int sent_words( input logic [7 : 0] di, input logic [15 : 0] wc,
                                   input int cls );
  if( cls == CLS_UNCORR && len_words( di, wc ) > 2 )
    return 2;
  return len_words( di, wc );
endfunction

// ==========================================================================
// Checks
// ==========================================================================

task automatic abort_run();
  $display( "CHECKS FAILED" );
  $fatal( 1 );
endtask

task automatic check_hdr( input string name, input csi2_pkg::hdr_word_t exp,
                          input csi2_pkg::hdr_word_t act );
  if( exp !== act )
    begin
      $display( "** Error %s: expected err=%b corr=%b di=%h wc=%h, actual %b %b %h %h",
                name, exp.f.pad[1], exp.f.pad[0], exp.f.di, exp.f.wc,
                act.f.pad[1], act.f.pad[0], act.f.di, act.f.wc );
      abort_run();
    end
endtask

task automatic check_word( input string name, input string what,
                           input logic [csi2_pkg::WORD_W - 1 : 0] exp,
                           input logic [csi2_pkg::WORD_W - 1 : 0] act );
  if( exp !== act )
    begin
      $display( "** Error %s: %s expected %h, actual %h", name, what, exp, act );
      abort_run();
    end
endtask

task automatic check_count( input string name, input string what,
                            input logic [csi2_pkg::CNT_W - 1 : 0] exp,
                            input logic [csi2_pkg::CNT_W - 1 : 0] act );
  if( exp !== act )
    begin
      $display( "** Error %s: %s expected %0d, actual %0d", name, what, exp, act );
      abort_run();
    end
endtask

task automatic check_flag( input string name, input string what,
                           input logic exp, input logic act );
  if( exp !== act )
    begin
      $display( "** Error %s: %s expected %b, actual %b", name, what, exp, act );
      abort_run();
    end
endtask

task automatic check_output();
  exp_item_t           item;
  csi2_pkg::hdr_word_t got;
  if( exp_q.size() == 0 )
    begin
      $display( "Output word at %0t with nothing left to expect", $time );
      abort_run();
    end
  else
    begin
      item = exp_q.pop_front();
      if( item.is_hdr != hdr_valid_o )
        begin
          $display( "%s: output kind (header %b) differs from the next expected item",
                    names[item.test], hdr_valid_o );
          abort_run();
        end
      else
        begin
          if( hdr_valid_o )
            begin
              got.raw   = '0;
              got.f.di  = hdr_di_o;
              got.f.wc  = hdr_wc_o;
              got.f.pad = { hdr_err_o, hdr_corr_o };
              check_hdr( names[item.test], item.hdr, got );
            end
          else
            check_word( names[item.test], "payload_o", item.word, payload_o );
          check_flag( names[item.test], "pkt_done_o", item.done, pkt_done_o );
        end
    end
endtask

// ==========================================================================
// Stimulus
// ==========================================================================

task automatic read_stimulus();
  int           fd;
  int           n;
  int           cls;
  string        line;
  string        nm;
  string        cls_s;
  logic [7 : 0]  di;
  logic [15 : 0] wc;
  logic [31 : 0] mask;
  fd = $fopen( "verification/csi2_rx_input.txt", "r" );
  if( fd == 0 )
    begin
      $display( "Cannot open verification/csi2_rx_input.txt" );
      abort_run();
    end
  else
    begin
      while( !$feof( fd ) )
        begin
          line = "";
          void'( $fgets( line, fd ) );
          if( line.len() < 2 || line[0] == "#" )
            continue;
          n   = $sscanf( line, "%s %h %h %h %s", nm, di, wc, mask, cls_s );
          cls = ( cls_s == "none" )          ? CLS_NONE :
                ( cls_s == "corrected" )     ? CLS_CORR :
                ( cls_s == "uncorrectable" ) ? CLS_UNCORR : -1;
          if( n != 5 || cls < 0 )
            begin
              $display( "Malformed stimulus line: %s", line );
              abort_run();
            end
          else
            begin
              names.push_back( nm );
              di_q.push_back( di );
              wc_q.push_back( wc );
              mask_q.push_back( mask );
              cls_q.push_back( cls );
              total_words += 1 + sent_words( di, wc, cls );
              if( cls != CLS_NONE && exp_err != '1 )
                exp_err = exp_err + 1'b1;
              if( cls == CLS_CORR && exp_corr != '1 )
                exp_corr = exp_corr + 1'b1;
            end
        end
      $fclose( fd );
    end
endtask

task automatic send_packet( input int t );
  csi2_pkg::hdr_word_t             sent;
  csi2_pkg::hdr_word_t             rcvd;
  exp_item_t                       item;
  logic [csi2_pkg::WORD_W - 1 : 0] word;
  int                              n_pay;
  int                              n_sent;
  int                              gap;
  sent.raw   = '0;
  sent.f.di  = di_q[t];
  sent.f.wc  = wc_q[t];
  sent.f.ecc = ecc_of( { wc_q[t], di_q[t] } );
  rcvd.raw   = sent.raw ^ mask_q[t];              // Injected channel errors.
  n_pay      = pay_words( di_q[t], wc_q[t], cls_q[t] );
  n_sent     = sent_words( di_q[t], wc_q[t], cls_q[t] );
  item           = '0;
  item.is_hdr    = 1'b1;
  item.done      = ( n_pay == 0 );
  item.test      = t[15 : 0];
  item.hdr       = ( cls_q[t] == CLS_UNCORR ) ? rcvd : sent;
  item.hdr.f.ecc = '0;
  item.hdr.f.pad = { cls_q[t] != CLS_NONE, cls_q[t] == CLS_CORR };
  exp_q.push_back( item );
  @( posedge clk_i );
  valid_i <= 1'b1;
  data_i  <= rcvd.raw;
  for( int i = 0; i < n_sent; i++ )
    begin
      word = $urandom();
      if( n_pay != 0 )
        begin
          item      = '0;
          item.test = t[15 : 0];
          item.word = word;
          item.done = ( i == n_pay - 1 );
          exp_q.push_back( item );
        end
      @( posedge clk_i );
      data_i <= word;
    end
  @( posedge clk_i );
  valid_i <= 1'b0;
  data_i  <= '0;
  gap = 3 + int'( $urandom() % 4 );              // Idle cycles between packets.
  repeat( gap - 1 )
    @( posedge clk_i );
endtask

// ==========================================================================
// Main flow, monitor and watchdog
// ==========================================================================

initial
  begin
    srst_i   = 1'b1;
    valid_i  = 1'b0;
    data_i   = '0;
    void'( $urandom( 8 ) );
    read_stimulus();
    loaded = 1'b1;
    repeat( 2 )
      @( posedge clk_i );
    srst_i <= 1'b0;
    for( int t = 0; t < names.size(); t++ )
      send_packet( t );
    while( exp_q.size() != 0 )
      @( posedge clk_i );
    repeat( 4 )
      @( posedge clk_i );                        // Catch stray pulses.
    check_count( "end_of_run", "err_cnt_o", exp_err, err_cnt_o );
    check_count( "end_of_run", "corr_cnt_o", exp_corr, corr_cnt_o );
    $display( "ALL CHECKS PASSED" );
    $finish;
  end

always @( negedge clk_i )
  if( !srst_i )
    begin
      if( hdr_valid_o || payload_valid_o )
        check_output();
      else
        if( pkt_done_o )
          begin
            $display( "pkt_done_o pulsed at %0t without a header or payload word", $time );
            abort_run();
          end
    end

initial
  begin
    wait( loaded );
    #( ( total_words + 8 * names.size() ) * CLK_PERIOD );
    $display( "timeout waiting for outputs" );
    abort_run();
  end

endmodule

// File: src.f
+incdir+include
source/csi2_pkg.sv
source/csi2_hdr_if.sv
source/csi2_syndrome_lut.sv
source/csi2_hamming_dec.sv
source/csi2_pkt_tracker.sv
source/csi2_rx_top.sv
verification/tb_clk_gen.sv
verification/csi2_rx_tb.sv

// File: verification/csi2_rx_input.txt
# test_name  di(hex)  wc(hex)  header_error_mask(hex)  expected_class
# class is none, corrected or uncorrectable
long_clean_raw8    2A 0010 00000000 none
long_clean_rgb888  24 0024 00000000 none
long_odd_wc        2B 000D 00000000 none
data_bit0          2A 0008 00000001 corrected
data_bit5          1E 0014 00000020 corrected
data_bit9          2A 000C 00000200 corrected
data_bit14         2C 0018 00004000 corrected
data_bit20         6A 0010 00100000 corrected
data_bit23         2A 0004 00800000 corrected
parity_bit24       2A 0010 01000000 corrected
parity_bit27       2B 0008 08000000 corrected
parity_bit29       2A 000C 20000000 corrected
double_data        2A 0010 00000011 uncorrectable
double_mixed       2A 0020 04000100 uncorrectable
short_frame_start  00 0001 00000000 none
short_line_start   02 0005 00000000 none
short_corrected    01 0002 00000400 corrected
short_double       03 0003 30000000 uncorrectable
